/* hdl/lc4_pkg.sv */
// LC4 pipeline shared definitions
`default_nettype none

package lc4_pkg;

  localparam int XLEN     = 16;           // Data and address width
  localparam int REG_AW   = 3;            // Register number width
  localparam int NUM_REGS = 8;            // R0..R7
  localparam logic [XLEN-1:0] RESET_PC = 16'h8200;  // First fetch after reset

  // Major opcode, insn[15:12]
  typedef enum logic [3:0] {
    NOP     = 4'b0000,  // Branch group, only the all-zero form is kept
    ARITH   = 4'b0001,
    LOGIC   = 4'b0101,
    LDR     = 4'b0110,
    STR     = 4'b0111,
    CONST   = 4'b1001,
    HICONST = 4'b1101
  } opcode_e;

  // ALU function, ADD doubles as address generation
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOT,
    ALU_CONST,
    ALU_HICONST
  } alu_op_e;

  // Source of an X-stage operand
  typedef enum logic [1:0] {
    BYP_RF,  // Register file value latched in X
    BYP_MX,  // ALU result sitting in M
    BYP_WX   // Writeback value in W
  } bypass_e;

  // Decoded control, carried D -> X -> M -> W
  typedef struct packed {
    opcode_e           opcode;
    alu_op_e           alu_op;
    logic [REG_AW-1:0] rs;
    logic              rs_re;
    logic [REG_AW-1:0] rt;
    logic              rt_re;
    logic [REG_AW-1:0] rd;
    logic              rf_we;
    logic              nzp_we;    // Tracks rf_we
    logic              is_load;
    logic              is_store;
    logic              use_imm;   // Operand B from imm
    logic [XLEN-1:0]   imm;       // Already extended
    logic              valid;     // Low for bubbles and NOPs
  } dec_ctrl_t;

  // All-zero control word is a bubble
  localparam dec_ctrl_t CTRL_BUBBLE = '0;

endpackage : lc4_pkg

`default_nettype wire

/* hdl/lc4_hazard_if.sv */
// Hazard controller interface
`timescale 1ns/1ps
`default_nettype none

interface lc4_hazard_if
  import lc4_pkg::*;
();

  // D-stage sources
  logic [REG_AW-1:0] d_rs, d_rt;
  logic              d_rs_re, d_rt_re;
  logic              stall;            // Load-use stall

  // X-stage instruction
  logic [REG_AW-1:0] x_rs, x_rt, x_rd;
  logic              x_rf_we, x_is_load;
  bypass_e           sel_a, sel_b;     // Operand sources for rs / rt

  // Older writers in M and W
  logic [REG_AW-1:0] m_rd, w_rd;
  logic              m_rf_we, w_rf_we;

  modport fd   (output d_rs, d_rt, d_rs_re, d_rt_re, input stall);
  modport ex   (output x_rs, x_rt, x_rd, x_rf_we, x_is_load, input sel_a, sel_b, stall);
  modport mw   (output m_rd, m_rf_we, w_rd, w_rf_we);
  modport ctrl (input d_rs, d_rt, d_rs_re, d_rt_re, x_rs, x_rt, x_rd, x_rf_we, x_is_load,
                input m_rd, m_rf_we, w_rd, w_rf_we,
                output stall, sel_a, sel_b);

endinterface : lc4_hazard_if

`default_nettype wire

/* hdl/lc4_hazard_ctrl.sv */
// Load-use stall and bypass select
`timescale 1ns/1ps
`default_nettype none

module lc4_hazard_ctrl
  import lc4_pkg::*;
(
  input wire         gwe,    // Global clock
  input wire         i_rst,  // Sync reset, active high
  lc4_hazard_if.ctrl hz
);

  logic x_writes_load;  // X holds a load that targets a register
  logic rs_hit, rt_hit;

  assign x_writes_load = hz.x_is_load && hz.x_rf_we;

  // Only sources actually read by D count
  assign rs_hit = hz.d_rs_re && (hz.d_rs == hz.x_rd);
  assign rt_hit = hz.d_rt_re && (hz.d_rt == hz.x_rd);

  // One bubble lets the load reach W, then WX covers it
  assign hz.stall = x_writes_load && (rs_hit || rt_hit);

  // Youngest writer wins, M before W
  function automatic bypass_e pick_src(input logic [REG_AW-1:0] src);
    bypass_e sel;
    if (hz.m_rf_we && (hz.m_rd == src)) begin
      sel = BYP_MX;
    end else if (hz.w_rf_we && (hz.w_rd == src)) begin
      sel = BYP_WX;
    end else begin
      sel = BYP_RF;  // Value read in D is current
    end
    return sel;
  endfunction

  assign hz.sel_a = pick_src(hz.x_rs);
  assign hz.sel_b = pick_src(hz.x_rt);

  // A stall puts a bubble in X, so the next cycle can never stall again
  a_stall_once: assert property (@(posedge gwe) disable iff (i_rst)
    hz.stall |=> !hz.stall)
    else $error("load-use stall held for two cycles");

endmodule : lc4_hazard_ctrl

`default_nettype wire

/* hdl/lc4_fetch_decode.sv */
// Fetch and decode stages
`timescale 1ns/1ps
`default_nettype none

module lc4_fetch_decode
  import lc4_pkg::*;
(
  input wire                gwe,
  input wire                i_rst,
  lc4_hazard_if.fd          hz,
  output logic [XLEN-1:0]   o_pc,      // Imem address
  input wire   [XLEN-1:0]   i_insn,    // Imem data in the same cycle
  output logic [REG_AW-1:0] o_rs_sel,  // Regfile read ports
  output logic [REG_AW-1:0] o_rt_sel,
  output dec_ctrl_t         o_d_ctrl
);

  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] d_insn;  // D-stage instruction register
  dec_ctrl_t       dec;
  logic            known;   // Recognized encoding

  // PC steps by one and freezes on stall
  always_ff @(posedge gwe) begin
    if (i_rst) pc <= RESET_PC;
    else if (!hz.stall) pc <= pc + 1'b1;
  end

  // Cleared D reads as NOP
  always_ff @(posedge gwe) begin
    if (i_rst) d_insn <= '0;
    else if (!hz.stall) d_insn <= i_insn;
  end

  always_comb begin
    dec       = CTRL_BUBBLE;
    known     = 1'b1;
    dec.rd    = d_insn[11:9];
    dec.rs    = d_insn[8:6];
    dec.rt    = d_insn[2:0];
    dec.rs_re = 1'b1;
    dec.rf_we = 1'b1;
    case (d_insn[15:12])
      ARITH: begin
        dec.opcode = ARITH;
        dec.imm    = {{11{d_insn[4]}}, d_insn[4:0]};  // imm5
        if (d_insn[5]) begin
          dec.use_imm = 1'b1;                         // ADD imm
        end else begin
          dec.rt_re  = 1'b1;
          dec.alu_op = (d_insn[4:3] == 2'b10) ? ALU_SUB : ALU_ADD;
          known      = (d_insn[5:3] == 3'b000) || (d_insn[5:3] == 3'b010);  // No MUL/DIV
        end
      end
      LOGIC: begin
        dec.opcode = LOGIC;
        dec.imm    = {{11{d_insn[4]}}, d_insn[4:0]};
        dec.alu_op = ALU_AND;
        if (d_insn[5]) begin
          dec.use_imm = 1'b1;                         // AND imm
        end else begin
          case (d_insn[4:3])
            2'b01:   dec.alu_op = ALU_NOT;
            2'b10:   dec.alu_op = ALU_OR;
            2'b11:   dec.alu_op = ALU_XOR;
            default: dec.alu_op = ALU_AND;
          endcase
          dec.rt_re = (d_insn[4:3] != 2'b01);         // NOT has one source
        end
      end
      LDR: begin
        dec.opcode  = LDR;
        dec.is_load = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm     = {{10{d_insn[5]}}, d_insn[5:0]}; // imm6
      end
      STR: begin
        dec.opcode   = STR;
        dec.rt       = d_insn[11:9];                  // Store data register
        dec.rt_re    = 1'b1;
        dec.rf_we    = 1'b0;
        dec.is_store = 1'b1;
        dec.use_imm  = 1'b1;
        dec.imm      = {{10{d_insn[5]}}, d_insn[5:0]};
      end
      CONST: begin
        dec.opcode = CONST;
        dec.alu_op = ALU_CONST;
        dec.rs_re  = 1'b0;
        dec.imm    = {{7{d_insn[8]}}, d_insn[8:0]};   // imm9
      end
      HICONST: begin
        dec.opcode = HICONST;
        dec.alu_op = ALU_HICONST;
        dec.rs     = d_insn[11:9];                    // Low byte kept from rd
        dec.imm    = {8'h00, d_insn[7:0]};
        known      = d_insn[8];
      end
      default: known = (d_insn == '0);                // Only plain NOP
    endcase
    if (!known || (d_insn[15:12] == NOP)) begin
      dec = CTRL_BUBBLE;
    end else begin
      dec.nzp_we = dec.rf_we;                         // CC follow every write
      dec.valid  = 1'b1;
    end
  end

  assign o_pc     = pc;
  assign o_d_ctrl = dec;
  assign o_rs_sel = dec.rs;
  assign o_rt_sel = dec.rt;

  assign hz.d_rs    = dec.rs;
  assign hz.d_rt    = dec.rt;
  assign hz.d_rs_re = dec.rs_re;
  assign hz.d_rt_re = dec.rt_re;

  // Unsupported words and branches decode as NOPs
  a_known_insn: assert property (@(posedge gwe) disable iff (i_rst) known)
    else $error("unknown instruction %h decoded as NOP", d_insn);

endmodule : lc4_fetch_decode

`default_nettype wire

/* hdl/lc4_regfile.sv */
// Eight-entry register file
`timescale 1ns/1ps
`default_nettype none

module lc4_regfile
  import lc4_pkg::*;
(
  input wire                gwe,
  input wire                i_rst,
  input wire   [REG_AW-1:0] i_rs,       // Read port A
  input wire   [REG_AW-1:0] i_rt,       // Read port B
  output logic [XLEN-1:0]   o_rs_data,
  output logic [XLEN-1:0]   o_rt_data,
  input wire                i_we,       // Write port from W
  input wire   [REG_AW-1:0] i_wsel,
  input wire   [XLEN-1:0]   i_wdata
);

  logic [XLEN-1:0] regs [NUM_REGS];

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we) begin
      regs[i_wsel] <= i_wdata;
    end
  end

  // Write-before-read, W feeds D directly
  assign o_rs_data = (i_we && (i_wsel == i_rs)) ? i_wdata : regs[i_rs];
  assign o_rt_data = (i_we && (i_wsel == i_rt)) ? i_wdata : regs[i_rt];

endmodule : lc4_regfile

`default_nettype wire

/* hdl/lc4_execute.sv */
// Execute stage with bypass and ALU
`timescale 1ns/1ps
`default_nettype none

module lc4_execute
  import lc4_pkg::*;
(
  input wire              gwe,
  input wire              i_rst,
  lc4_hazard_if.ex        hz,
  input wire dec_ctrl_t   i_d_ctrl,
  input wire [XLEN-1:0]   i_rs_data,       // Regfile values read in D
  input wire [XLEN-1:0]   i_rt_data,
  input wire [XLEN-1:0]   i_m_result,      // MX source
  input wire [XLEN-1:0]   i_w_data,        // WX source
  output dec_ctrl_t       o_x_ctrl,
  output logic [XLEN-1:0] o_x_result,
  output logic [XLEN-1:0] o_x_store_data
);

  dec_ctrl_t       x_ctrl;
  logic [XLEN-1:0] x_rs_data, x_rt_data;  // Operands latched from D
  logic [XLEN-1:0] op_a, op_rt, op_b;
  logic [XLEN-1:0] alu_out;

  // Stall sends a bubble down while D holds
  always_ff @(posedge gwe) begin
    if (i_rst || hz.stall) x_ctrl <= CTRL_BUBBLE;
    else x_ctrl <= i_d_ctrl;
  end

  always_ff @(posedge gwe) begin
    x_rs_data <= i_rs_data;
    x_rt_data <= i_rt_data;
  end

  assign hz.x_rs      = x_ctrl.rs;
  assign hz.x_rt      = x_ctrl.rt;
  assign hz.x_rd      = x_ctrl.rd;
  assign hz.x_rf_we   = x_ctrl.rf_we;
  assign hz.x_is_load = x_ctrl.is_load;

  function automatic logic [XLEN-1:0] byp_mux(input bypass_e sel,
                                              input logic [XLEN-1:0] rf_val);
    logic [XLEN-1:0] val;
    case (sel)
      BYP_MX:  val = i_m_result;
      BYP_WX:  val = i_w_data;
      default: val = rf_val;
    endcase
    return val;
  endfunction

  assign op_a  = byp_mux(hz.sel_a, x_rs_data);
  assign op_rt = byp_mux(hz.sel_b, x_rt_data);
  assign op_b  = x_ctrl.use_imm ? x_ctrl.imm : op_rt;

  always_comb begin
    case (x_ctrl.alu_op)
      ALU_ADD:     alu_out = op_a + op_b;          // Also LDR/STR address
      ALU_SUB:     alu_out = op_a - op_b;
      ALU_AND:     alu_out = op_a & op_b;
      ALU_OR:      alu_out = op_a | op_b;
      ALU_XOR:     alu_out = op_a ^ op_b;
      ALU_NOT:     alu_out = ~op_a;
      ALU_CONST:   alu_out = x_ctrl.imm;
      ALU_HICONST: alu_out = {x_ctrl.imm[7:0], op_a[7:0]};  // New high byte
      default:     alu_out = '0;
    endcase
  end

  assign o_x_ctrl       = x_ctrl;
  assign o_x_result     = alu_out;
  assign o_x_store_data = op_rt;  // Bypassed rt goes to memory

endmodule : lc4_execute

`default_nettype wire

/* hdl/lc4_mem_wb.sv */
// Memory and writeback stages
`timescale 1ns/1ps
`default_nettype none

module lc4_mem_wb
  import lc4_pkg::*;
(
  input wire                gwe,
  input wire                i_rst,
  lc4_hazard_if.mw          hz,
  input wire dec_ctrl_t     i_x_ctrl,
  input wire   [XLEN-1:0]   i_x_result,
  input wire   [XLEN-1:0]   i_x_store_data,
  output logic [XLEN-1:0]   o_m_result,     // MX bypass value
  output logic [XLEN-1:0]   o_dmem_addr,
  output logic              o_dmem_we,
  output logic [XLEN-1:0]   o_dmem_wdata,
  input wire   [XLEN-1:0]   i_dmem_data,    // Dmem answers in M
  output logic              o_w_we,
  output logic [REG_AW-1:0] o_w_sel,
  output logic [XLEN-1:0]   o_w_data,
  output logic              o_wb_valid,     // One pulse per retirement
  output logic              o_nzp_we,
  output logic [2:0]        o_nzp
);

  dec_ctrl_t       m_ctrl, w_ctrl;
  logic [XLEN-1:0] m_result, m_store_data;
  logic [XLEN-1:0] w_result, w_load;

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      m_ctrl <= CTRL_BUBBLE;
      w_ctrl <= CTRL_BUBBLE;
    end else begin
      m_ctrl <= i_x_ctrl;
      w_ctrl <= m_ctrl;
    end
  end

  always_ff @(posedge gwe) begin
    m_result     <= i_x_result;
    m_store_data <= i_x_store_data;
    w_result     <= m_result;
    w_load       <= i_dmem_data;  // Load data captured at end of M
  end

  // Port idles at zero for non-memory instructions
  assign o_dmem_addr  = (m_ctrl.is_load || m_ctrl.is_store) ? m_result : '0;
  assign o_dmem_we    = m_ctrl.is_store;
  assign o_dmem_wdata = m_ctrl.is_store ? m_store_data : '0;
  assign o_m_result   = m_result;

  assign o_w_data   = w_ctrl.is_load ? w_load : w_result;
  assign o_w_we     = w_ctrl.rf_we;
  assign o_w_sel    = w_ctrl.rd;
  assign o_wb_valid = w_ctrl.valid;
  assign o_nzp_we   = w_ctrl.nzp_we;
  assign o_nzp      = {o_w_data[XLEN-1],                 // N
                       o_w_data == '0,                   // Z
                       !o_w_data[XLEN-1] && |o_w_data};  // P

  assign hz.m_rd    = m_ctrl.rd;
  assign hz.m_rf_we = m_ctrl.rf_we;
  assign hz.w_rd    = w_ctrl.rd;
  assign hz.w_rf_we = w_ctrl.rf_we;

  // Decode must never mark one instruction as both load and store
  a_we_not_load: assert property (@(posedge gwe) disable iff (i_rst)
    !(o_dmem_we && m_ctrl.is_load))
    else $error("dmem write during a load");

endmodule : lc4_mem_wb

`default_nettype wire

/* hdl/lc4_core.sv */
// LC4 five-stage pipeline top
`timescale 1ns/1ps
`default_nettype none

module lc4_core
  import lc4_pkg::*;
(
  input wire           gwe,           // Global clock
  input wire           i_rst,
  output logic [15:0]  o_pc,          // Imem address
  input wire   [15:0]  i_insn,
  output logic [15:0]  o_dmem_addr,   // Zero for non-memory instructions
  input wire   [15:0]  i_dmem_data,
  output logic         o_dmem_we,
  output logic [15:0]  o_dmem_wdata,
  output logic         o_wb_valid,    // Retirement trace
  output logic         o_rf_we,
  output logic [2:0]   o_rf_wsel,
  output logic [15:0]  o_rf_wdata,
  output logic         o_nzp_we,
  output logic [2:0]   o_nzp
);

  dec_ctrl_t         d_ctrl, x_ctrl;
  logic [REG_AW-1:0] rs_sel, rt_sel;
  logic [XLEN-1:0]   rs_data, rt_data;
  logic [XLEN-1:0]   x_result, x_store_data;
  logic [XLEN-1:0]   m_result;

  lc4_hazard_if hz_if ();

  lc4_hazard_ctrl u_hazard_ctrl (.gwe(gwe), .i_rst(i_rst), .hz(hz_if.ctrl));

  lc4_fetch_decode u_fetch_decode (
    .gwe(gwe), .i_rst(i_rst), .hz(hz_if.fd),
    .o_pc(o_pc), .i_insn(i_insn),
    .o_rs_sel(rs_sel), .o_rt_sel(rt_sel), .o_d_ctrl(d_ctrl)
  );

  // Written from W, read from D
  lc4_regfile u_regfile (
    .gwe(gwe), .i_rst(i_rst),
    .i_rs(rs_sel), .i_rt(rt_sel), .o_rs_data(rs_data), .o_rt_data(rt_data),
    .i_we(o_rf_we), .i_wsel(o_rf_wsel), .i_wdata(o_rf_wdata)
  );

  lc4_execute u_execute (
    .gwe(gwe), .i_rst(i_rst), .hz(hz_if.ex),
    .i_d_ctrl(d_ctrl), .i_rs_data(rs_data), .i_rt_data(rt_data),
    .i_m_result(m_result), .i_w_data(o_rf_wdata),
    .o_x_ctrl(x_ctrl), .o_x_result(x_result), .o_x_store_data(x_store_data)
  );

  lc4_mem_wb u_mem_wb (
    .gwe(gwe), .i_rst(i_rst), .hz(hz_if.mw),
    .i_x_ctrl(x_ctrl), .i_x_result(x_result), .i_x_store_data(x_store_data),
    .o_m_result(m_result),
    .o_dmem_addr(o_dmem_addr), .o_dmem_we(o_dmem_we), .o_dmem_wdata(o_dmem_wdata),
    .i_dmem_data(i_dmem_data),
    .o_w_we(o_rf_we), .o_w_sel(o_rf_wsel), .o_w_data(o_rf_wdata),
    .o_wb_valid(o_wb_valid), .o_nzp_we(o_nzp_we), .o_nzp(o_nzp)
  );

endmodule : lc4_core

`default_nettype wire

/* dv/lc4_prog_table.svh */
// LC4 program and retirement table
`ifndef LC4_PROG_TABLE_SVH
`define LC4_PROG_TABLE_SVH

  // One row per instruction in program order from RESET_PC
  // Columns are insn, rf_we, wsel, wdata, ld, st, addr, sdata
  // ld set means the expected value is the memory model word at addr
  // st set means a data memory write of sdata to addr
  typedef struct packed {
    logic [15:0] insn;
    logic        rf_we;
    logic [2:0]  wsel;
    logic [15:0] wdata;  // Ignored when ld is set
    logic        ld;
    logic        st;
    logic [15:0] addr;   // Address for ld and st rows
    logic [15:0] sdata;
  } prog_row_t;

  localparam int PROG_LEN = 21;

  localparam prog_row_t PROG [PROG_LEN] = '{
    '{16'h93FB, 1'b1, 3'd1, 16'hFFFB, 1'b0, 1'b0, 16'h0000, 16'h0000},  // CONST R1,#-5
    '{16'h9464, 1'b1, 3'd2, 16'h0064, 1'b0, 1'b0, 16'h0000, 16'h0000},  // CONST R2,#100
    '{16'h1642, 1'b1, 3'd3, 16'h005F, 1'b0, 1'b0, 16'h0000, 16'h0000},  // ADD R3,R1,R2
    '{16'h18D1, 1'b1, 3'd4, 16'h0064, 1'b0, 1'b0, 16'h0000, 16'h0000},  // SUB R4,R3,R1
    '{16'h5AC4, 1'b1, 3'd5, 16'h0044, 1'b0, 1'b0, 16'h0000, 16'h0000},  // AND R5,R3,R4
    '{16'h5D51, 1'b1, 3'd6, 16'hFFFF, 1'b0, 1'b0, 16'h0000, 16'h0000},  // OR R6,R5,R1
    '{16'h5F9D, 1'b1, 3'd7, 16'hFFBB, 1'b0, 1'b0, 16'h0000, 16'h0000},  // XOR R7,R6,R5
    '{16'h51C8, 1'b1, 3'd0, 16'h0044, 1'b0, 1'b0, 16'h0000, 16'h0000},  // NOT R0,R7
    '{16'h103C, 1'b1, 3'd0, 16'h0040, 1'b0, 1'b0, 16'h0000, 16'h0000},  // ADD R0,R0,#-4
    '{16'h522F, 1'b1, 3'd1, 16'h0000, 1'b0, 1'b0, 16'h0000, 16'h0000},  // AND R1,R0,#15
    '{16'h9434, 1'b1, 3'd2, 16'h0034, 1'b0, 1'b0, 16'h0000, 16'h0000},  // CONST R2,#0x34
    '{16'hD512, 1'b1, 3'd2, 16'h1234, 1'b0, 1'b0, 16'h0000, 16'h0000},  // HICONST R2,#0x12
    '{16'h7403, 1'b0, 3'd0, 16'h0000, 1'b0, 1'b1, 16'h0043, 16'h1234},  // STR R2,R0,#3
    '{16'h6603, 1'b1, 3'd3, 16'h0000, 1'b1, 1'b0, 16'h0043, 16'h0000},  // LDR R3,R0,#3
    '{16'h18C3, 1'b1, 3'd4, 16'h2468, 1'b0, 1'b0, 16'h0000, 16'h0000},  // ADD R4,R3,R3
    '{16'h6A05, 1'b1, 3'd5, 16'h0000, 1'b1, 1'b0, 16'h0045, 16'h0000},  // LDR R5,R0,#5
    '{16'h1D60, 1'b1, 3'd6, 16'h0000, 1'b1, 1'b0, 16'h0045, 16'h0000},  // ADD R6,R5,#0
    '{16'h6E03, 1'b1, 3'd7, 16'h0000, 1'b1, 1'b0, 16'h0043, 16'h0000},  // LDR R7,R0,#3
    '{16'h7E07, 1'b0, 3'd0, 16'h0000, 1'b0, 1'b1, 16'h0047, 16'h1234},  // STR R7,R0,#7
    '{16'h6207, 1'b1, 3'd1, 16'h0000, 1'b1, 1'b0, 16'h0047, 16'h0000},  // LDR R1,R0,#7
    '{16'h1454, 1'b1, 3'd2, 16'hEDCC, 1'b0, 1'b0, 16'h0000, 16'h0000}   // SUB R2,R1,R4
  };

`endif

/* dv/lc4_core_tb.sv */
// LC4 pipeline testbench
`timescale 1ns/1ps
`default_nettype none

module lc4_core_tb
  import lc4_pkg::*;
();

  `include "lc4_prog_table.svh"

  localparam int RETIRE_TIMEOUT = 16;     // Cycles allowed between retirements
  localparam int MEM_WORDS      = 65536;  // Full 16-bit data address space

  logic        gwe = 1'b0;
  logic        i_rst = 1'b1;
  logic [15:0] i_insn = 16'h0000;
  logic [15:0] i_dmem_data = 16'h0000;
  logic [15:0] o_pc, o_dmem_addr, o_dmem_wdata, o_rf_wdata;
  logic        o_dmem_we, o_wb_valid, o_rf_we, o_nzp_we;
  logic [2:0]  o_rf_wsel, o_nzp;

  logic [15:0] dmem [MEM_WORDS];     // Memory the DUT sees
  logic [15:0] ref_mem [MEM_WORDS];  // Expected contents with table stores applied
  logic [15:0] st_addr_q [$];        // Port writes in arrival order
  logic [15:0] st_data_q [$];
  int          dmem_writes;
  int          errors;
  bit          row_bad;              // Current test has a mismatch

  lc4_core i_dut (
    .gwe(gwe), .i_rst(i_rst),
    .o_pc(o_pc), .i_insn(i_insn),
    .o_dmem_addr(o_dmem_addr), .i_dmem_data(i_dmem_data),
    .o_dmem_we(o_dmem_we), .o_dmem_wdata(o_dmem_wdata),
    .o_wb_valid(o_wb_valid), .o_rf_we(o_rf_we), .o_rf_wsel(o_rf_wsel),
    .o_rf_wdata(o_rf_wdata), .o_nzp_we(o_nzp_we), .o_nzp(o_nzp)
  );

  always #20 gwe = ~gwe;  // 40 ns period

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Program words from RESET_PC on and NOP elsewhere
  function automatic logic [15:0] fetch_word(input logic [15:0] pc);
    logic [15:0] idx;
    logic [15:0] word;
    idx  = pc - RESET_PC;
    word = 16'h0000;
    if ((pc >= RESET_PC) && (int'(idx) < PROG_LEN)) word = PROG[int'(idx)].insn;
    return word;
  endfunction

  // Condition codes from the sign of a written value
  function automatic logic [2:0] nzp_of(input logic [15:0] v);
    logic [2:0] cc;
    if (v[15]) cc = 3'b100;
    else if (v == 16'h0000) cc = 3'b010;
    else cc = 3'b001;
    return cc;
  endfunction

  // Both memories answer from the addresses held since the last rising edge
  always @(negedge gwe) begin
    if (o_dmem_we) begin
      dmem[o_dmem_addr] = o_dmem_wdata;
      st_addr_q.push_back(o_dmem_addr);
      st_data_q.push_back(o_dmem_wdata);
      dmem_writes++;
    end
    i_insn      <= fetch_word(o_pc);
    i_dmem_data <= dmem[o_dmem_addr];
  end

  task automatic check_eq(input string sig, input logic [15:0] got, input logic [15:0] want);
    assert (got === want)
    else begin
      $display("FAILED t=%0t %s got %h expected %h", $time, sig, got, want);
      errors++;
      row_bad = 1'b1;
    end
  endtask

  // Steps falling edges until a retirement shows up
  task automatic wait_retire(output bit seen);
    int n;
    seen = 1'b0;
    for (n = 0; (n < RETIRE_TIMEOUT) && !seen; n++) begin
      @(negedge gwe);
      seen = o_wb_valid;
    end
  endtask

  task automatic check_row(input int i);
    prog_row_t   r;
    logic [15:0] want;
    r = PROG[i];
    check_eq("o_rf_we", 16'(o_rf_we), 16'(r.rf_we));
    check_eq("o_nzp_we", 16'(o_nzp_we), 16'(r.rf_we));  // CC written with every register
    if (r.rf_we) begin
      want = r.ld ? ref_mem[r.addr] : r.wdata;
      check_eq("o_rf_wsel", 16'(o_rf_wsel), 16'(r.wsel));
      check_eq("o_rf_wdata", o_rf_wdata, want);
      check_eq("o_nzp", 16'(o_nzp), 16'(nzp_of(want)));
    end
    if (r.st) begin
      assert (st_addr_q.size() > 0)
      else begin
        $display("store of test %0d retired without a data memory write", i);
        errors++;
        row_bad = 1'b1;
      end
      if (st_addr_q.size() > 0) begin
        check_eq("o_dmem_addr", st_addr_q.pop_front(), r.addr);
        check_eq("o_dmem_wdata", st_data_q.pop_front(), r.sdata);
      end
      ref_mem[r.addr] = r.sdata;  // Later loads see the stored word
    end
  endtask

  initial begin
    logic [31:0] state;
    bit          seen;
    int          passed;
    int          n_stores;
    errors      = 0;
    dmem_writes = 0;
    passed      = 0;
    n_stores    = 0;
    row_bad     = 1'b0;
    state       = 32'd65;
    for (int a = 0; a < MEM_WORDS; a++) begin
      state      = xorshift(state);
      dmem[a]    = state[15:0] ^ 16'(a);  // Every address bit shows in the word
      ref_mem[a] = dmem[a];
    end
    repeat (16) @(posedge gwe);
    @(negedge gwe);
    // Reset state, fetch parked at the first program word
    check_eq("o_pc", o_pc, RESET_PC);
    check_eq("o_wb_valid", 16'(o_wb_valid), 16'h0000);
    check_eq("o_rf_we", 16'(o_rf_we), 16'h0000);
    check_eq("o_nzp_we", 16'(o_nzp_we), 16'h0000);
    check_eq("o_dmem_we", 16'(o_dmem_we), 16'h0000);
    i_rst = 1'b0;
    for (int i = 0; i < PROG_LEN; i++) begin
      row_bad = 1'b0;
      wait_retire(seen);
      assert (seen)
      else begin
        $display("timeout: test %0d (insn %h) never retired", i, PROG[i].insn);
        errors++;
      end
      if (!seen) break;
      if (PROG[i].st) n_stores++;
      check_row(i);
      if (!row_bad) passed++;
      $display("test %2d insn %h %s", i, PROG[i].insn, row_bad ? "fail" : "ok");
    end
    // Exactly one port write per retired store
    assert ((dmem_writes == n_stores) && (st_addr_q.size() == 0))
    else begin
      $display("expected %0d data memory writes, saw %0d", n_stores, dmem_writes);
      errors++;
    end
    $display("%0d of %0d tests passed, %0d errors", passed, PROG_LEN, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : lc4_core_tb

`default_nettype wire

/* filelist.f */
+incdir+dv
hdl/lc4_pkg.sv
hdl/lc4_hazard_if.sv
hdl/lc4_hazard_ctrl.sv
hdl/lc4_fetch_decode.sv
hdl/lc4_regfile.sv
hdl/lc4_execute.sv
hdl/lc4_mem_wb.sv
hdl/lc4_core.sv
dv/lc4_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the LC4 testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module lc4_core_tb -Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed"
  exit 1
fi

./obj_dir/Vlc4_core_tb > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "ERRORS FOUND" "$SIM_LOG"; then
  exit 1
fi
exit 0
